/* Makefile */
TOP := gps_core_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)
	verilator --lint-only -Wall logic/gps_pkg.sv logic/epoch_bank.sv logic/sample_buffer.sv \
		logic/serial_readout.sv logic/gps_core.sv --top-module gps_core

clean:
	rm -rf obj_dir

/* dv/gps_core_tb.sv */
//////////////////////////////
// Testbench for gps_core at default parameters with a cycle model beside the DUT
// Model assumes no phase load and group reset in the same cycle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gps_core_tb;

    localparam int GPS_CHANS      = 4;
    localparam int CODE_LEN       = 1023;
    localparam int SAMPLE_WORDS   = 16;
    localparam int NSRQ           = GPS_CHANS + 1;
    localparam int SNAP_W         = 48 + GPS_CHANS * 17;
    localparam int NBITS          = SAMPLE_WORDS * 16;
    // Roughly twice the scheduled tests, which include two full code periods
    localparam int TIMEOUT_CYCLES = 6000;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  host_srq;
    logic                  I_data = 1'b0;
    logic                  wrReg;
    logic                  rdReg;
    logic                  rdBit;
    logic                  wrEvt;
    gps_pkg::op_t          op;
    gps_pkg::tos_t         tos;
    logic                  gps_rd;
    gps_pkg::word_t        gps_dout;
    logic                  ser;

    // Reference model state
    int                    m_phase [GPS_CHANS];
    logic [GPS_CHANS-1:0]  m_epoch;
    logic [GPS_CHANS-1:0]  m_mask;
    logic [NSRQ-1:0]       m_noted;
    logic [47:0]           m_ticks;
    int                    m_chan_sel;
    logic                  m_sample;
    logic                  m_bits [NBITS];
    int                    m_nbits;
    int                    m_rdptr;
    logic [SNAP_W-1:0]     exp_word;

    logic [31:0]           rng = 32'h0644cd09;
    int                    errors = 0;
    int                    cycles = 0;
    int                    rd_pulses = 0;

    gps_core #(
        .GPS_CHANS    (GPS_CHANS),
        .CODE_LEN     (CODE_LEN),
        .SAMPLE_WORDS (SAMPLE_WORDS)
    ) UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .host_srq (host_srq),
        .I_data   (I_data),
        .wrReg    (wrReg),
        .rdReg    (rdReg),
        .rdBit    (rdBit),
        .wrEvt    (wrEvt),
        .op       (op),
        .tos      (tos),
        .gps_rd   (gps_rd),
        .gps_dout (gps_dout),
        .ser      (ser)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function void report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endfunction

    // First captured bit of a word is its MSB
    function automatic gps_pkg::word_t model_word(input int w);
        gps_pkg::word_t packed_w;
        packed_w = '0;
        if (w < SAMPLE_WORDS) begin
            for (int b = 0; b < 16; b++) begin
                packed_w[15-b] = m_bits[w*16+b];
            end
        end
        return packed_w;
    endfunction

    task automatic write_reg(input int sel, input int value);
        @(posedge clk);
        wrReg <= 1'b1;
        op    <= gps_pkg::op_t'(1) << sel;
        tos   <= gps_pkg::tos_t'(value);
        @(posedge clk);
        wrReg <= 1'b0;
        op    <= '0;
        tos   <= '0;
    endtask

    task automatic fire_event(input int sel);
        @(posedge clk);
        wrEvt <= 1'b1;
        op    <= gps_pkg::op_t'(1) << sel;
        @(posedge clk);
        wrEvt <= 1'b0;
        op    <= '0;
    endtask

    // Load a register and compare every shifted bit, MSB first
    task automatic read_reg(input int sel, input int nbits);
        @(posedge clk);
        rdReg <= 1'b1;
        op    <= gps_pkg::op_t'(1) << sel;
        @(posedge clk);
        rdReg <= 1'b0;
        op    <= '0;
        rdBit <= 1'b1;
        for (int i = nbits - 1; i >= 0; i--) begin
            @(negedge clk);
            a_ser: assert (ser === exp_word[i])
                else report_mismatch($sformatf("ser bit %0d is %b, expected %b", i, ser,
                                               exp_word[i]));
            @(posedge clk);
        end
        rdBit <= 1'b0;
    endtask

    task automatic read_samples();
        @(posedge clk);
        wrEvt <= 1'b1;
        op    <= gps_pkg::op_t'(1) << gps_pkg::GET_SAMPLES;
        repeat (SAMPLE_WORDS) @(posedge clk);
        wrEvt <= 1'b0;
        op    <= '0;
    endtask

    //////////////////////////////
    // Stimulus for the antenna bit

    always @(posedge clk) begin
        rng    <= lcg_next(rng);
        I_data <= rng[31];
    end

    //////////////////////////////
    // Reference model on the same edges and inputs as the DUT

    always @(posedge clk or negedge arst_n) begin
        logic [NSRQ-1:0]   flags;
        logic [SNAP_W-1:0] loaded;
        if (!arst_n) begin
            for (int ch = 0; ch < GPS_CHANS; ch++) begin
                m_phase[ch] <= 0;
            end
            m_epoch    <= '0;
            m_mask     <= '0;
            m_noted    <= '0;
            m_ticks    <= '0;
            m_chan_sel <= 0;
            m_sample   <= 1'b0;
            m_nbits    <= 0;
            m_rdptr    <= 0;
            exp_word   <= '0;
        end else begin
            flags = {host_srq, m_epoch};
            m_ticks <= m_ticks + 48'd1;
            if (wrReg && op[gps_pkg::SET_CHAN]) begin
                m_chan_sel <= int'(tos[3:0]);
            end
            if (wrReg && op[gps_pkg::SET_MASK]) begin
                m_mask <= tos[GPS_CHANS-1:0];
            end
            // Group reset, then host load, then the wrap
            for (int ch = 0; ch < GPS_CHANS; ch++) begin
                if (wrEvt && op[gps_pkg::SAMPLER_RST] && !m_mask[ch]) begin
                    m_phase[ch] <= 0;
                    m_epoch[ch] <= 1'b0;
                end else if (wrReg && op[gps_pkg::SET_PHASE] && m_chan_sel == ch) begin
                    m_phase[ch] <= int'(tos[15:0]);
                    m_epoch[ch] <= 1'b0;
                end else if (m_phase[ch] == CODE_LEN - 1) begin
                    m_phase[ch] <= 0;
                    m_epoch[ch] <= 1'b1;
                end else begin
                    m_phase[ch] <= m_phase[ch] + 1;
                    m_epoch[ch] <= 1'b0;
                end
            end
            // Masked request word where the host bit always passes
            if (rdReg && op[gps_pkg::GET_SRQ]) begin
                loaded = '0;
                loaded[NSRQ-1:0] = m_noted & {1'b1, m_mask};
                exp_word <= loaded;
                m_noted  <= flags;
            end else begin
                m_noted <= m_noted | flags;
            end
            if (rdReg && op[gps_pkg::GET_SNAPSHOT]) begin
                loaded = '0;
                loaded[SNAP_W-1 -: 48] = m_ticks;
                loaded[GPS_CHANS*16 +: GPS_CHANS] = m_epoch | m_noted[GPS_CHANS-1:0];
                for (int ch = 0; ch < GPS_CHANS; ch++) begin
                    loaded[ch*16 +: 16] = m_phase[ch][15:0];
                end
                exp_word <= loaded;
            end
            // Capture runs one stage behind I_data
            m_sample <= I_data;
            if (wrEvt && op[gps_pkg::SAMPLER_RST]) begin
                m_nbits <= 0;
                m_rdptr <= 0;
            end else begin
                if (m_nbits < NBITS) begin
                    m_bits[m_nbits] <= m_sample;
                    m_nbits         <= m_nbits + 1;
                end
                if (wrEvt && op[gps_pkg::GET_SAMPLES]) begin
                    m_rdptr <= m_rdptr + 1;
                end
            end
        end
    end

    //////////////////////////////
    // Output checks at the falling edge

    a_reset_quiet: assert property (
        @(negedge clk) !arst_n |-> (!ser && !gps_rd && gps_dout == '0)
    ) else report_mismatch("outputs not idle during reset");

    a_rd_strobe: assert property (
        @(negedge clk) disable iff (!arst_n)
        gps_rd == (wrEvt && op[gps_pkg::GET_SAMPLES])
    ) else report_mismatch("gps_rd does not follow the sample read strobe");

    a_dout: assert property (
        @(negedge clk) disable iff (!arst_n)
        gps_dout == ((wrEvt && op[gps_pkg::GET_SAMPLES]) ? model_word(m_rdptr) : '0)
    ) else report_mismatch($sformatf("gps_dout %h, expected %h for word %0d", gps_dout,
                                     model_word(m_rdptr), m_rdptr));

    always @(negedge clk) begin
        if (arst_n && gps_rd) begin
            rd_pulses++;
        end
    end

    //////////////////////////////
    // Test sequence

    initial begin
        arst_n   = 1'b0;
        host_srq = 1'b0;
        wrReg    = 1'b0;
        rdReg    = 1'b0;
        rdBit    = 1'b0;
        wrEvt    = 1'b0;
        op       = '0;
        tos      = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state, then the host request alone
        read_reg(gps_pkg::GET_SRQ, NSRQ);
        @(posedge clk);
        host_srq <= 1'b1;
        @(posedge clk);
        host_srq <= 1'b0;
        read_reg(gps_pkg::GET_SRQ, NSRQ);

        // Epoch requests from staggered phases near the wrap
        write_reg(gps_pkg::SET_MASK, (1 << GPS_CHANS) - 1);
        for (int ch = 0; ch < GPS_CHANS; ch++) begin
            write_reg(gps_pkg::SET_CHAN, ch);
            write_reg(gps_pkg::SET_PHASE, CODE_LEN - 3 - 6 * ch);
        end
        read_reg(gps_pkg::GET_SRQ, NSRQ);
        read_reg(gps_pkg::GET_SRQ, NSRQ);
        repeat (CODE_LEN) @(posedge clk);
        read_reg(gps_pkg::GET_SRQ, NSRQ);

        // Masked channel 1 stays unserviced in the snapshot
        write_reg(gps_pkg::SET_MASK, ((1 << GPS_CHANS) - 1) & ~2);
        write_reg(gps_pkg::SET_CHAN, 1);
        write_reg(gps_pkg::SET_PHASE, CODE_LEN - 5);
        repeat (10) @(posedge clk);
        read_reg(gps_pkg::GET_SNAPSHOT, SNAP_W);
        read_reg(gps_pkg::GET_SRQ, NSRQ);
        repeat (CODE_LEN) @(posedge clk);
        read_reg(gps_pkg::GET_SRQ, NSRQ);

        // Group reset of channel 1 alone as seen in the snapshot
        fire_event(gps_pkg::SAMPLER_RST);
        read_reg(gps_pkg::GET_SNAPSHOT, SNAP_W);

        // Capture fills after the reset strobe, then read it all back
        wait (m_nbits == NBITS);
        read_samples();
        @(negedge clk);
        a_rd_count: assert (rd_pulses == SAMPLE_WORDS)
            else report_mismatch($sformatf("%0d sample reads seen, expected %0d", rd_pulses,
                                           SAMPLE_WORDS));

        $display("Summary: %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/epoch_bank.sv */
//////////////////////////////
// Code-phase counters, one per channel, wrapping at CODE_LEN
// Host must load phases below CODE_LEN; a larger value wraps at the next edge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module epoch_bank #(
    parameter int GPS_CHANS = 4,
    parameter int CODE_LEN  = 1023
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  phase_wr,
    input  logic                                  sampler_rst,
    input  gps_pkg::chan_t                        chan_sel,
    input  gps_pkg::tos_t                         tos,
    input  logic [GPS_CHANS-1:0]                  chan_mask,
    output logic [GPS_CHANS-1:0]                  epoch,
    output gps_pkg::phase_t [GPS_CHANS-1:0]       phases
);

    // Last phase before the wrap
    localparam gps_pkg::phase_t LAST = gps_pkg::phase_t'(CODE_LEN - 1);
    localparam int PW = $bits(gps_pkg::phase_t);

    //////////////////////////////
    // Per-channel replica counter

    for (genvar ch = 0; ch < GPS_CHANS; ch++) begin : g_chan

        gps_pkg::phase_t phase_q;
        logic            epoch_q;
        logic            load;
        logic            clear;
        logic            wrap;

        // Host load hits only the selected channel
        assign load  = phase_wr && (chan_sel == gps_pkg::chan_t'(ch));
        // Group reset spares the channels the host keeps alive
        assign clear = sampler_rst && !chan_mask[ch];
        // Greater-or-equal also recovers from an out-of-range load
        assign wrap  = (phase_q >= LAST);

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                phase_q <= '0;
                epoch_q <= 1'b0;
            end else if (clear) begin
                phase_q <= '0;
                epoch_q <= 1'b0;
            end else if (load) begin
                // Loaded value holds for one cycle, counting resumes next edge
                phase_q <= tos[PW-1:0];
                epoch_q <= 1'b0;
            end else if (wrap) begin
                phase_q <= '0;
                epoch_q <= 1'b1;
            end else begin
                phase_q <= phase_q + gps_pkg::phase_t'(1);
                epoch_q <= 1'b0;
            end
        end

        assign phases[ch] = phase_q;
        assign epoch[ch]  = epoch_q;

        // Host loads and group resets must never push a replica out of range
        a_phase_range: assert property (
            @(posedge clk) disable iff (!arst_n)
            phase_q < gps_pkg::phase_t'(CODE_LEN)
        ) else $error("epoch_bank: channel %0d phase %0d out of range", ch, phase_q);

    end

endmodule

`default_nettype wire

/* logic/gps_core.sv */
//////////////////////////////
// Channel-service top level, single clock domain, no handshake on strobes
// GPS_CHANS limited to 1..16 by the channel select width
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gps_core #(
    parameter int GPS_CHANS    = 4,
    parameter int CODE_LEN     = 1023,
    parameter int SAMPLE_WORDS = 16
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           host_srq,
    input  logic           I_data,
    input  logic           wrReg,
    input  logic           rdReg,
    input  logic           rdBit,
    input  logic           wrEvt,
    input  gps_pkg::op_t   op,
    input  gps_pkg::tos_t  tos,
    output logic           gps_rd,
    output gps_pkg::word_t gps_dout,
    output logic           ser
);

    localparam int CHW = $bits(gps_pkg::chan_t);

    if (GPS_CHANS < 1 || GPS_CHANS > (1 << CHW)) begin : g_bad_chans
        $error("gps_core: GPS_CHANS must be between 1 and %0d", 1 << CHW);
    end

    gps_pkg::chan_t                  chan_sel;
    logic                            phase_wr;
    logic                            mask_wr;
    logic                            sampler_rst;
    logic                            sampler_rd;
    logic [GPS_CHANS-1:0]            epoch;
    logic [GPS_CHANS-1:0]            chan_mask;
    gps_pkg::phase_t [GPS_CHANS-1:0] phases;
    gps_pkg::word_t                  word_out;

    //////////////////////////////
    // Command decode

    assign phase_wr    = wrReg && op[gps_pkg::SET_PHASE];
    assign mask_wr     = wrReg && op[gps_pkg::SET_MASK];
    assign sampler_rst = wrEvt && op[gps_pkg::SAMPLER_RST];
    assign sampler_rd  = wrEvt && op[gps_pkg::GET_SAMPLES];

    // Channel addressed by later phase loads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chan_sel <= '0;
        end else if (wrReg && op[gps_pkg::SET_CHAN]) begin
            chan_sel <= tos[CHW-1:0];
        end
    end

    //////////////////////////////
    // Producer, buffer, consumer

    epoch_bank #(.GPS_CHANS(GPS_CHANS), .CODE_LEN(CODE_LEN)) u_epoch_bank (
        .clk         (clk),
        .arst_n      (arst_n),
        .phase_wr    (phase_wr),
        .sampler_rst (sampler_rst),
        .chan_sel    (chan_sel),
        .tos         (tos),
        .chan_mask   (chan_mask),
        .epoch       (epoch),
        .phases      (phases)
    );

    sample_buffer #(.SAMPLE_WORDS(SAMPLE_WORDS)) u_sample_buffer (
        .clk         (clk),
        .arst_n      (arst_n),
        .I_data      (I_data),
        .sampler_rst (sampler_rst),
        .sampler_rd  (sampler_rd),
        .word_out    (word_out)
    );

    serial_readout #(.GPS_CHANS(GPS_CHANS)) u_serial_readout (
        .clk       (clk),
        .arst_n    (arst_n),
        .host_srq  (host_srq),
        .rdReg     (rdReg),
        .rdBit     (rdBit),
        .mask_wr   (mask_wr),
        .op        (op),
        .tos       (tos),
        .epoch     (epoch),
        .phases    (phases),
        .chan_mask (chan_mask),
        .ser       (ser)
    );

    //////////////////////////////
    // Host read bus

    // Bus idles at zero between sample reads
    assign gps_rd   = sampler_rd;
    assign gps_dout = sampler_rd ? word_out : '0;

endmodule

`default_nettype wire

/* logic/gps_pkg.sv */
//////////////////////////////
// Widths and op bit positions shared by the channel-service block
// chan_t is 4 bits, so at most 16 channels can be addressed
//////////////////////////////

`default_nettype none

package gps_pkg;

    //////////////////////////////
    // Widths with a meaning

    // Sample word, also the width of the host read bus
    typedef logic [15:0] word_t;
    // One-hot command qualifier bus
    typedef logic [15:0] op_t;
    // Command data, top of stack on the host side
    typedef logic [31:0] tos_t;
    // Code phase of one channel replica
    typedef logic [15:0] phase_t;
    // System tick count
    typedef logic [47:0] ticks_t;
    // Channel index
    typedef logic [3:0] chan_t;

    //////////////////////////////
    // Op bit positions

    // Qualifiers of wrReg
    localparam int SET_CHAN     = 0;
    localparam int SET_MASK     = 1;
    localparam int SET_PHASE    = 2;

    // Qualifiers of rdReg, they also pick what ser follows
    localparam int GET_SRQ      = 1;
    localparam int GET_SNAPSHOT = 2;

    // Qualifiers of wrEvt
    localparam int SAMPLER_RST  = 3;
    localparam int GET_SAMPLES  = 4;

endpackage

`default_nettype wire

/* logic/sample_buffer.sv */
//////////////////////////////
// Packs I_data MSB first into 16-bit words, stops when SAMPLE_WORDS are stored
// No back-pressure: host reads only words already written
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
    parameter int SAMPLE_WORDS = 16
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           I_data,
    input  logic           sampler_rst,
    input  logic           sampler_rd,
    output gps_pkg::word_t word_out
);

    localparam int WW = $bits(gps_pkg::word_t);
    // Word count needs one value more than the depth
    localparam int CW = $clog2(SAMPLE_WORDS + 1);
    localparam int AW = (SAMPLE_WORDS > 1) ? $clog2(SAMPLE_WORDS) : 1;

    typedef logic [CW-1:0]          count_t;
    typedef logic [$clog2(WW)-1:0]  bitcnt_t;

    logic           sample;
    gps_pkg::word_t shift_q;
    bitcnt_t        bit_cnt;
    count_t         wr_ptr;
    count_t         rd_ptr;
    logic           full;
    logic           word_done;

    gps_pkg::word_t mem [SAMPLE_WORDS];

    //////////////////////////////
    // Input sampling

    // One register stage on the antenna bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= 1'b0;
        end else begin
            sample <= I_data;
        end
    end

    //////////////////////////////
    // Bit packer and write side

    assign full      = (wr_ptr == count_t'(SAMPLE_WORDS));
    // Sixteenth bit of the current word arrives this edge
    assign word_done = !full && (bit_cnt == bitcnt_t'(WW - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
            wr_ptr  <= '0;
        end else if (sampler_rst) begin
            bit_cnt <= '0;
            wr_ptr  <= '0;
        end else if (!full) begin
            bit_cnt <= bit_cnt + bitcnt_t'(1);
            if (word_done) begin
                wr_ptr <= wr_ptr + count_t'(1);
            end
        end
    end

    // Shifter and memory hold payload only
    always_ff @(posedge clk) begin
        if (!sampler_rst && !full) begin
            shift_q <= {shift_q[WW-2:0], sample};
        end
        if (!sampler_rst && word_done) begin
            mem[wr_ptr[AW-1:0]] <= {shift_q[WW-2:0], sample};
        end
    end

    //////////////////////////////
    // Read side

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (sampler_rst) begin
            rd_ptr <= '0;
        end else if (sampler_rd) begin
            rd_ptr <= rd_ptr + count_t'(1);
        end
    end

    // Word at the read pointer, top level gates it with gps_rd
    assign word_out = mem[rd_ptr[AW-1:0]];

    // Host pacing must keep reads behind the capture
    a_no_underrun: assert property (
        @(posedge clk) disable iff (!arst_n)
        (sampler_rd && !sampler_rst) |-> (rd_ptr != wr_ptr)
    ) else $error("sample_buffer: read of word %0d before it was written", rd_ptr);

endmodule

`default_nettype wire

/* logic/serial_readout.sv */
//////////////////////////////
// Service-request and snapshot shift-out on ser, one bit per rdBit
// rdReg picks the register ser follows until the next rdReg
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module serial_readout #(
    parameter int GPS_CHANS = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            host_srq,
    input  logic                            rdReg,
    input  logic                            rdBit,
    input  logic                            mask_wr,
    input  gps_pkg::op_t                    op,
    input  gps_pkg::tos_t                   tos,
    input  logic [GPS_CHANS-1:0]            epoch,
    input  gps_pkg::phase_t [GPS_CHANS-1:0] phases,
    output logic [GPS_CHANS-1:0]            chan_mask,
    output logic                            ser
);

    // Channel flags plus the host flag on top
    localparam int NSRQ   = GPS_CHANS + 1;
    localparam int TW     = $bits(gps_pkg::ticks_t);
    localparam int PW     = $bits(gps_pkg::phase_t);
    localparam int SNAP_W = TW + GPS_CHANS * (PW + 1);

    logic [NSRQ-1:0]   srq_flags;
    logic [NSRQ-1:0]   srq_mask;
    logic [NSRQ-1:0]   srq_noted;
    logic [NSRQ-1:0]   srq_shift;
    logic [SNAP_W-1:0] snap_next;
    logic [SNAP_W-1:0] snapshot;
    gps_pkg::ticks_t   ticks;
    logic              load_srq;
    logic              load_snap;
    logic              sel_srq;
    logic              sel_snap;

    //////////////////////////////
    // Command qualifiers

    assign load_srq  = rdReg && op[gps_pkg::GET_SRQ];
    assign load_snap = rdReg && op[gps_pkg::GET_SNAPSHOT];

    // Register ser follows, held until the next rdReg
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_srq  <= 1'b0;
            sel_snap <= 1'b0;
        end else if (rdReg) begin
            sel_srq  <= op[gps_pkg::GET_SRQ];
            sel_snap <= op[gps_pkg::GET_SNAPSHOT];
        end
    end

    //////////////////////////////
    // Service mask

    // Mask bit 0 hides the channel from the request word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chan_mask <= '0;
        end else if (mask_wr) begin
            chan_mask <= tos[GPS_CHANS-1:0];
        end
    end

    //////////////////////////////
    // Sticky service requests

    assign srq_flags = {host_srq, epoch};
    // Host request is never masked
    assign srq_mask  = {1'b1, chan_mask};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            srq_noted <= '0;
        end else if (load_srq) begin
            // Restart from what is pending right now
            srq_noted <= srq_flags;
        end else begin
            srq_noted <= srq_noted | srq_flags;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            srq_shift <= '0;
        end else if (load_srq) begin
            srq_shift <= srq_noted & srq_mask;
        end else if (rdBit && sel_srq) begin
            srq_shift <= {srq_shift[NSRQ-2:0], 1'b0};
        end
    end

    //////////////////////////////
    // Tick counter

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ticks <= '0;
        end else begin
            ticks <= ticks + gps_pkg::ticks_t'(1);
        end
    end

    //////////////////////////////
    // Snapshot

    // Ticks, unserviced epochs, then phases with the top channel first
    assign snap_next = {ticks, epoch | srq_noted[GPS_CHANS-1:0], phases};

    always_ff @(posedge clk) begin
        if (load_snap) begin
            snapshot <= snap_next;
        end else if (rdBit && sel_snap) begin
            snapshot <= {snapshot[SNAP_W-2:0], 1'b0};
        end
    end

    // MSB of the selected register, zero when nothing is selected
    assign ser = (sel_srq && srq_shift[NSRQ-1]) || (sel_snap && snapshot[SNAP_W-1]);

    // Both selects at once would OR two streams on ser
    a_one_select: assert property (
        @(posedge clk) disable iff (!arst_n)
        rdReg |-> !(op[gps_pkg::GET_SRQ] && op[gps_pkg::GET_SNAPSHOT])
    ) else $error("serial_readout: rdReg selects both request and snapshot");

endmodule

`default_nettype wire

/* project.f */
logic/gps_pkg.sv
logic/epoch_bank.sv
logic/sample_buffer.sv
logic/serial_readout.sv
logic/gps_core.sv
dv/gps_core_tb.sv
